// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/alu_lane.sv ====
`include "exe_defs.svh"

module alu_lane (
    input  exe_op_pkg::lane_req_t req_i,
    input  muldiv_pkg::md_res_t   hilo_i,
    output exe_op_pkg::lane_res_t res_o
);

    localparam int W     = `EXE_DATA_W;
    localparam int SH_W  = $clog2(W);

    logic [W-1:0]    a;
    logic [W-1:0]    b;
    logic [W-1:0]    sum;
    logic [W-1:0]    diff;
    logic [SH_W-1:0] shamt;

    assign a     = req_i.src_a;
    assign b     = req_i.src_b;
    assign sum   = a + b;
    assign diff  = a - b;

    // Shifts take the amount from src_a and shift src_b, like sllv.
    assign shamt = a[SH_W-1:0];

    always_comb begin
        res_o = '0;
        case (req_i.op)
            exe_op_pkg::OP_ADD: begin
                res_o.data     = sum;
                res_o.overflow = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
            end
            exe_op_pkg::OP_ADDU: res_o.data = sum;
            exe_op_pkg::OP_SUB: begin
                res_o.data     = diff;
                res_o.overflow = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
            end
            exe_op_pkg::OP_SUBU: res_o.data = diff;
            exe_op_pkg::OP_AND:  res_o.data = a & b;
            exe_op_pkg::OP_OR:   res_o.data = a | b;
            exe_op_pkg::OP_XOR:  res_o.data = a ^ b;
            exe_op_pkg::OP_NOR:  res_o.data = ~(a | b);
            exe_op_pkg::OP_SLT:  res_o.data = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            exe_op_pkg::OP_SLTU: res_o.data = {{(W-1){1'b0}}, a < b};
            exe_op_pkg::OP_SLL:  res_o.data = b << shamt;
            exe_op_pkg::OP_SRL:  res_o.data = b >> shamt;
            exe_op_pkg::OP_SRA:  res_o.data = $signed(b) >>> shamt;
            exe_op_pkg::OP_LUI:  res_o.data = {b[W/2-1:0], {(W/2){1'b0}}};
            exe_op_pkg::OP_TEQ:  res_o.trap = (a == b);
            exe_op_pkg::OP_MFHI: res_o.data = hilo_i.hi;
            exe_op_pkg::OP_MFLO: res_o.data = hilo_i.lo;
            default: ;
        endcase
    end

endmodule

// ==== hw/exe_op_pkg.sv ====
`include "exe_defs.svh"

package exe_op_pkg;

    // Simple ALU operations sit in the low range, hilo-class ones from 6'h20.
    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_ADDU  = 6'h02,
        OP_SUB   = 6'h03,
        OP_SUBU  = 6'h04,
        OP_AND   = 6'h05,
        OP_OR    = 6'h06,
        OP_XOR   = 6'h07,
        OP_NOR   = 6'h08,
        OP_SLT   = 6'h09,
        OP_SLTU  = 6'h0a,
        OP_SLL   = 6'h0b,
        OP_SRL   = 6'h0c,
        OP_SRA   = 6'h0d,
        OP_LUI   = 6'h0e,
        OP_TEQ   = 6'h0f,
        OP_MFHI  = 6'h10,
        OP_MFLO  = 6'h11,
        OP_MULT  = 6'h20,
        OP_MULTU = 6'h21,
        OP_DIV   = 6'h22,
        OP_DIVU  = 6'h23,
        OP_MADD  = 6'h24,
        OP_MADDU = 6'h25,
        OP_MSUB  = 6'h26,
        OP_MSUBU = 6'h27,
        OP_MTHI  = 6'h28,
        OP_MTLO  = 6'h29
    } exe_op_e;

    typedef struct packed {
        exe_op_e                op;
        logic [`EXE_DATA_W-1:0] src_a;
        logic [`EXE_DATA_W-1:0] src_b;
    } lane_req_t;

    typedef struct packed {
        logic [`EXE_DATA_W-1:0] data;
        logic                   overflow;
        logic                   trap;
    } lane_res_t;

endpackage

// ==== hw/exe_top.sv ====
`include "exe_defs.svh"

module exe_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  exe_op_pkg::lane_req_t lane0_i,
    input  exe_op_pkg::lane_req_t lane1_i,
    input  logic [1:0]            flush_i,
    output exe_op_pkg::lane_res_t res0_o,
    output exe_op_pkg::lane_res_t res1_o,
    output logic                  stall_o
);

    muldiv_pkg::md_req_t     md_req;
    logic                    md_start;
    muldiv_pkg::md_res_t     md_res;
    logic                    timer_load;
    logic [`EXE_TIMER_W-1:0] timer_count;
    logic                    timer_cancel;
    logic                    timer_done;
    logic                    step_tick;
    muldiv_pkg::hilo_wr_t    hilo_wr;
    muldiv_pkg::md_res_t     hilo_q;

    alu_lane alu0_i (
        .req_i  (lane0_i),
        .hilo_i (hilo_q),
        .res_o  (res0_o)
    );

    alu_lane alu1_i (
        .req_i  (lane1_i),
        .hilo_i (hilo_q),
        .res_o  (res1_o)
    );

    muldiv_ctrl ctrl_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .lane0_i        (lane0_i),
        .lane1_i        (lane1_i),
        .flush_i        (flush_i),
        .timer_done_i   (timer_done),
        .md_start_o     (md_start),
        .md_req_o       (md_req),
        .timer_load_o   (timer_load),
        .timer_count_o  (timer_count),
        .timer_cancel_o (timer_cancel),
        .hilo_wr_o      (hilo_wr),
        .stall_o        (stall_o)
    );

    step_timer timer_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .load_i   (timer_load),
        .count_i  (timer_count),
        .cancel_i (timer_cancel),
        .tick_o   (step_tick),
        .done_o   (timer_done)
    );

    muldiv_datapath datapath_i (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (md_start),
        .req_i   (md_req),
        .step_i  (step_tick),
        .res_o   (md_res)
    );

    hilo_unit hilo_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .wr_i     (hilo_wr),
        .md_res_i (md_res),
        .hilo_o   (hilo_q)
    );

endmodule

// ==== hw/hilo_unit.sv ====
`include "exe_defs.svh"

module hilo_unit (
    input  logic                 clk,
    input  logic                 reset_i,
    input  muldiv_pkg::hilo_wr_t wr_i,
    input  muldiv_pkg::md_res_t  md_res_i,
    output muldiv_pkg::md_res_t  hilo_o
);

    localparam int W = `EXE_DATA_W;

    logic [2*W-1:0] pair_q;

    assign hilo_o = pair_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pair_q <= '0;
        end else if (wr_i.wr_en) begin
            case (wr_i.op)
                exe_op_pkg::OP_MADD, exe_op_pkg::OP_MADDU: pair_q <= pair_q + md_res_i;
                exe_op_pkg::OP_MSUB, exe_op_pkg::OP_MSUBU: pair_q <= pair_q - md_res_i;
                exe_op_pkg::OP_MTHI: pair_q[2*W-1:W] <= wr_i.a;
                exe_op_pkg::OP_MTLO: pair_q[W-1:0]   <= wr_i.a;
                default: pair_q <= md_res_i;
            endcase
        end
    end

endmodule

// ==== hw/muldiv_ctrl.sv ====
`include "exe_defs.svh"

module muldiv_ctrl (
    input  logic                       clk,
    input  logic                       reset_i,
    input  exe_op_pkg::lane_req_t      lane0_i,
    input  exe_op_pkg::lane_req_t      lane1_i,
    input  logic [1:0]                 flush_i,
    input  logic                       timer_done_i,
    output logic                       md_start_o,
    output muldiv_pkg::md_req_t        md_req_o,
    output logic                       timer_load_o,
    output logic [`EXE_TIMER_W-1:0]    timer_count_o,
    output logic                       timer_cancel_o,
    output muldiv_pkg::hilo_wr_t       hilo_wr_o,
    output logic                       stall_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FINISH} state_e;

    state_e                state_q;
    state_e                state_d;
    logic                  lane_q;
    exe_op_pkg::exe_op_e   op_q;

    logic                  sel_lane;
    exe_op_pkg::lane_req_t sel_req;
    logic                  sel_hilo;
    muldiv_pkg::md_kind_e  sel_kind;
    logic                  own_flush;

    function automatic logic is_hilo_op(input exe_op_pkg::exe_op_e op);
        return op inside {exe_op_pkg::OP_MULT, exe_op_pkg::OP_MULTU, exe_op_pkg::OP_DIV,
                          exe_op_pkg::OP_DIVU, exe_op_pkg::OP_MADD, exe_op_pkg::OP_MADDU,
                          exe_op_pkg::OP_MSUB, exe_op_pkg::OP_MSUBU, exe_op_pkg::OP_MTHI,
                          exe_op_pkg::OP_MTLO};
    endfunction

    function automatic muldiv_pkg::md_kind_e op_kind(input exe_op_pkg::exe_op_e op);
        case (op)
            exe_op_pkg::OP_DIV, exe_op_pkg::OP_DIVU: return muldiv_pkg::MD_DIV;
            exe_op_pkg::OP_MTHI, exe_op_pkg::OP_MTLO: return muldiv_pkg::MD_MOVE;
            default: return muldiv_pkg::MD_MUL;
        endcase
    endfunction

    ///////////////////////////////
    // Lane selection
    ///////////////////////////////

    // Lane 0 owns the unit whenever it carries a hilo-class operation.
    assign sel_lane  = !is_hilo_op(lane0_i.op);
    assign sel_req   = sel_lane ? lane1_i : lane0_i;
    assign sel_hilo  = is_hilo_op(sel_req.op);
    assign sel_kind  = op_kind(sel_req.op);
    assign own_flush = flush_i[lane_q];

    assign md_req_o.kind      = sel_kind;
    assign md_req_o.is_signed = sel_req.op inside {exe_op_pkg::OP_MULT, exe_op_pkg::OP_DIV,
                                                   exe_op_pkg::OP_MADD, exe_op_pkg::OP_MSUB};
    assign md_req_o.a         = sel_req.src_a;
    assign md_req_o.b         = sel_req.src_b;

    assign timer_count_o = (sel_kind == muldiv_pkg::MD_DIV) ?
                           `EXE_TIMER_W'(`EXE_DIV_CYCLES) : `EXE_TIMER_W'(`EXE_MUL_CYCLES);

    ///////////////////////////////
    // State machine
    ///////////////////////////////

    always_comb begin
        state_d        = state_q;
        md_start_o     = 1'b0;
        timer_load_o   = 1'b0;
        timer_cancel_o = 1'b0;
        stall_o        = 1'b0;
        hilo_wr_o      = '0;
        case (state_q)
            ST_IDLE: begin
                if (sel_hilo && !flush_i[sel_lane]) begin
                    if (sel_kind == muldiv_pkg::MD_MOVE) begin
                        hilo_wr_o.wr_en = 1'b1;
                        hilo_wr_o.op    = sel_req.op;
                        hilo_wr_o.a     = sel_req.src_a;
                    end else begin
                        md_start_o   = 1'b1;
                        timer_load_o = 1'b1;
                        stall_o      = 1'b1;
                        state_d      = ST_RUN;
                    end
                end
            end
            ST_RUN: begin
                if (own_flush) begin
                    timer_cancel_o = 1'b1;
                    state_d        = ST_IDLE;
                end else begin
                    stall_o = 1'b1;
                    if (timer_done_i) begin
                        state_d = ST_FINISH;
                    end
                end
            end
            default: begin
                // The result is final, so the pair is written at this edge.
                hilo_wr_o.wr_en = !own_flush;
                hilo_wr_o.op    = op_q;
                state_d         = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            lane_q  <= 1'b0;
            op_q    <= exe_op_pkg::OP_NOP;
        end else begin
            state_q <= state_d;
            if (md_start_o) begin
                lane_q <= sel_lane;
                op_q   <= sel_req.op;
            end
        end
    end

endmodule

// ==== hw/muldiv_datapath.sv ====
`include "exe_defs.svh"

module muldiv_datapath (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                step_i,
    output muldiv_pkg::md_res_t res_o
);

    localparam int W = `EXE_DATA_W;

    muldiv_pkg::md_kind_e kind_q;
    logic                 neg_a_q;
    logic                 neg_b_q;
    logic [W-1:0]         a_q;
    logic [W-1:0]         b_q;
    logic [2*W-1:0]       acc_q;

    logic                 neg_a;
    logic                 neg_b;
    logic [W-1:0]         mag_a;
    logic [W-1:0]         mag_b;
    logic [W:0]           rem_sh;
    logic [W+1:0]         trial;
    logic [2*W-1:0]       div_next;
    logic [2*W-1:0]       prod;

    assign neg_a = req_i.is_signed && req_i.a[W-1];
    assign neg_b = req_i.is_signed && req_i.b[W-1];
    assign mag_a = neg_a ? -req_i.a : req_i.a;
    assign mag_b = neg_b ? -req_i.b : req_i.b;

    ///////////////////////////////
    // Restoring divide step
    ///////////////////////////////

    // Remainder lives in the upper half, the dividend shifts out of the lower.
    assign rem_sh   = acc_q[2*W-1:W-1];
    assign trial    = {1'b0, rem_sh} - {2'b00, b_q};
    assign div_next = trial[W+1] ? {acc_q[2*W-2:0], 1'b0}
                                 : {trial[W-1:0], acc_q[W-2:0], 1'b1};

    assign prod = {{W{1'b0}}, a_q} * {{W{1'b0}}, b_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            kind_q  <= muldiv_pkg::MD_MOVE;
            neg_a_q <= 1'b0;
            neg_b_q <= 1'b0;
        end else if (start_i) begin
            kind_q  <= req_i.kind;
            neg_a_q <= neg_a;
            neg_b_q <= neg_b;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q   <= mag_a;
            b_q   <= mag_b;
            acc_q <= {{W{1'b0}}, mag_a};
        end else if (step_i) begin
            case (kind_q)
                muldiv_pkg::MD_MUL: acc_q <= prod;
                muldiv_pkg::MD_DIV: acc_q <= div_next;
                default: ;
            endcase
        end
    end

    ///////////////////////////////
    // Sign correction
    ///////////////////////////////

    always_comb begin
        res_o = acc_q;
        case (kind_q)
            muldiv_pkg::MD_MUL: begin
                if (neg_a_q ^ neg_b_q) begin
                    res_o = -acc_q;
                end
            end
            muldiv_pkg::MD_DIV: begin
                // Quotient sign from both operands, remainder follows the dividend.
                res_o.lo = (neg_a_q ^ neg_b_q) ? -acc_q[W-1:0] : acc_q[W-1:0];
                res_o.hi = neg_a_q ? -acc_q[2*W-1:W] : acc_q[2*W-1:W];
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/muldiv_pkg.sv ====
`include "exe_defs.svh"

package muldiv_pkg;

    typedef enum logic [1:0] {
        MD_MUL  = 2'd0,
        MD_DIV  = 2'd1,
        MD_MOVE = 2'd2
    } md_kind_e;

    typedef struct packed {
        md_kind_e               kind;
        logic                   is_signed;
        logic [`EXE_DATA_W-1:0] a;
        logic [`EXE_DATA_W-1:0] b;
    } md_req_t;

    typedef struct packed {
        logic [`EXE_DATA_W-1:0] hi;
        logic [`EXE_DATA_W-1:0] lo;
    } md_res_t;

    // The op selects load, accumulate, subtract or a move into one half.
    typedef struct packed {
        logic                   wr_en;
        exe_op_pkg::exe_op_e    op;
        logic [`EXE_DATA_W-1:0] a;
    } hilo_wr_t;

endpackage

// ==== hw/step_timer.sv ====
`include "exe_defs.svh"

module step_timer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    load_i,
    input  logic [`EXE_TIMER_W-1:0] count_i,
    input  logic                    cancel_i,
    output logic                    tick_o,
    output logic                    done_o
);

    logic [`EXE_TIMER_W-1:0] cnt_q;
    logic                    done_q;

    assign tick_o = (cnt_q != '0) && !cancel_i;
    assign done_o = done_q;

    // Done follows the last tick, so the final step is already registered.
    always_ff @(posedge clk) begin
        if (reset_i || cancel_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (load_i) begin
            cnt_q  <= count_i;
            done_q <= 1'b0;
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            done_q <= (cnt_q == `EXE_TIMER_W'(1));
        end
    end

endmodule

// ==== include/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// Width of one operand and of each half of HI/LO.
`define EXE_DATA_W 32

// Width of the step timer counter, large enough for the divide count.
`define EXE_TIMER_W 6

// Timer load for a multiply.
`define EXE_MUL_CYCLES 3

// Timer load for a divide, one restoring step per quotient bit.
`define EXE_DIV_CYCLES 32

`endif

// ==== tb.f ====
+incdir+include
hw/exe_op_pkg.sv
hw/muldiv_pkg.sv
hw/alu_lane.sv
hw/muldiv_ctrl.sv
hw/step_timer.sv
hw/muldiv_datapath.sv
hw/hilo_unit.sv
hw/exe_top.sv
verification/exe_chk.sv
verification/exe_tb.sv

// ==== verification/exe_chk.sv ====
`include "exe_defs.svh"

module exe_chk (
    input logic                  clk,
    input logic                  reset_i,
    input exe_op_pkg::lane_req_t lane0_i,
    input logic [1:0]            flush_i,
    input logic                  stall_i,
    input logic                  md_start_i,
    input logic                  step_tick_i,
    input muldiv_pkg::hilo_wr_t  hilo_wr_i
);

    int         fail_cnt = 0;
    logic       owner_q;
    logic       move_lane;
    logic       wr_lane;
    logic [7:0] stall_cnt_q;

    // Lane 0 wins the unit whenever it carries a hilo-class operation.
    assign move_lane = !(lane0_i.op inside {[exe_op_pkg::OP_MULT:exe_op_pkg::OP_MTLO]});
    assign wr_lane   = (hilo_wr_i.op inside {exe_op_pkg::OP_MTHI, exe_op_pkg::OP_MTLO}) ?
                       move_lane : owner_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q     <= 1'b0;
            stall_cnt_q <= '0;
        end else begin
            if (md_start_i) begin
                owner_q <= move_lane;
            end
            stall_cnt_q <= stall_i ? stall_cnt_q + 8'd1 : 8'd0;
        end
    end

    reset_quiet: assert property (@(posedge clk) reset_i |=> !stall_i)
        else begin $error("stall is high right after reset"); fail_cnt++; end

    start_idle: assert property (@(posedge clk) disable iff (reset_i)
        md_start_i |-> !step_tick_i)
        else begin $error("unit started while the timer runs"); fail_cnt++; end

    stall_bound: assert property (@(posedge clk) disable iff (reset_i)
        stall_i |-> stall_cnt_q < 8'(`EXE_DIV_CYCLES + 2))
        else begin $error("stall held longer than a divide"); fail_cnt++; end

    flush_no_write: assert property (@(posedge clk) disable iff (reset_i)
        hilo_wr_i.wr_en |-> !flush_i[wr_lane])
        else begin $error("HI/LO written for a flushed lane"); fail_cnt++; end

endmodule

bind exe_top exe_chk chk_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .lane0_i     (lane0_i),
    .flush_i     (flush_i),
    .stall_i     (stall_o),
    .md_start_i  (md_start),
    .step_tick_i (step_tick),
    .hilo_wr_i   (hilo_wr)
);

// ==== verification/exe_patterns.txt ====
# op0 a0 b0 op1 a1 b1 flush, then expected data0 ovf0 trap0 data1 ovf1 trap1 (all hex)
# flush bit 0 is lane 0; for a multiply or divide it arrives one cycle after the start
01 00000005 00000003 02 ffffffff 00000001 0 00000008 0 0 00000000 0 0
01 7fffffff 00000001 03 80000000 00000001 0 80000000 1 0 7fffffff 1 0
04 00000000 00000001 02 7fffffff 00000001 0 ffffffff 0 0 80000000 0 0
01 80000000 80000000 03 00000010 00000003 0 00000000 1 0 0000000d 0 0
05 f0f0f0f0 ff00ff00 06 0f0f0000 0000f0f0 0 f000f000 0 0 0f0ff0f0 0 0
07 aaaa5555 ffff0000 08 0000ffff 00ff0000 0 55555555 0 0 ff000000 0 0
09 ffffffff 00000001 0a ffffffff 00000001 0 00000001 0 0 00000000 0 0
09 00000005 fffffffb 0a 00000001 ffffffff 0 00000000 0 0 00000001 0 0
0b 00000004 0000000f 0c 00000008 80000000 0 000000f0 0 0 00800000 0 0
0d 00000024 f0000000 0e 00000000 00001234 0 ff000000 0 0 12340000 0 0
0f 00000007 00000007 0f 00000007 00000008 0 00000000 0 1 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 00000000 0 0 00000000 0 0
20 00000006 00000007 01 00000001 00000002 0 00000000 0 0 00000003 0 0
10 00000000 00000000 11 00000000 00000000 0 00000000 0 0 0000002a 0 0
20 fffffffd 00000004 00 00000000 00000000 0 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 ffffffff 0 0 fffffff4 0 0
21 ffffffff 00000002 00 00000000 00000000 0 00000000 0 0 00000000 0 0
11 00000000 00000000 10 00000000 00000000 0 fffffffe 0 0 00000001 0 0
22 fffffff9 00000002 00 00000000 00000000 0 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 ffffffff 0 0 fffffffd 0 0
01 00000010 00000020 23 00000064 00000007 0 00000030 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 00000002 0 0 0000000e 0 0
22 00000007 fffffffe 00 00000000 00000000 0 00000000 0 0 00000000 0 0
11 00000000 00000000 10 00000000 00000000 0 fffffffd 0 0 00000001 0 0
28 00000000 00000000 00 00000000 00000000 0 00000000 0 0 00000000 0 0
00 00000000 00000000 29 00000010 00000000 0 00000000 0 0 00000000 0 0
24 00000003 00000004 00 00000000 00000000 0 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 00000000 0 0 0000001c 0 0
26 00000005 00000008 00 00000000 00000000 0 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 ffffffff 0 0 fffffff4 0 0
25 ffffffff 00000010 00 00000000 00000000 0 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 0000000f 0 0 ffffffe4 0 0
27 00000002 00000003 00 00000000 00000000 0 00000000 0 0 00000000 0 0
11 00000000 00000000 10 00000000 00000000 0 ffffffde 0 0 0000000f 0 0
22 00000064 00000005 00 00000000 00000000 1 00000000 0 0 00000000 0 0
28 12345678 00000000 00 00000000 00000000 1 00000000 0 0 00000000 0 0
10 00000000 00000000 11 00000000 00000000 0 0000000f 0 0 ffffffde 0 0

// ==== verification/exe_tb.sv ====
`include "exe_defs.svh"

module exe_tb;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_IDLE     = 3;

    logic                  clk;
    logic                  reset_i;
    exe_op_pkg::lane_req_t lane0;
    exe_op_pkg::lane_req_t lane1;
    logic [1:0]            flush;
    exe_op_pkg::lane_res_t res0;
    exe_op_pkg::lane_res_t res1;
    logic                  stall;

    exe_op_pkg::lane_req_t pat_lane0[$];
    exe_op_pkg::lane_req_t pat_lane1[$];
    logic [1:0]            pat_flush[$];
    exe_op_pkg::lane_res_t exp_res0[$];
    exe_op_pkg::lane_res_t exp_res1[$];

    int data_errs   = 0;
    int flag_errs   = 0;
    int stall_errs  = 0;
    int other_errs  = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    exe_top exe_top_i (
        .clk     (clk),
        .reset_i (reset_i),
        .lane0_i (lane0),
        .lane1_i (lane1),
        .flush_i (flush),
        .res0_o  (res0),
        .res1_o  (res1),
        .stall_o (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the patterns did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // Pattern file
    //////////////////////////////

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        logic [5:0]  op0;
        logic [5:0]  op1;
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] a1;
        logic [31:0] b1;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [1:0]  fl;
        logic        o0;
        logic        t0;
        logic        o1;
        logic        t1;
        fd = $fopen("verification/exe_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file could not be opened");
            other_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op0, a0, b0, op1, a1, b1, fl, d0, o0, t0, d1, o1, t1);
            if (n != 13) begin
                $display("a pattern line could not be parsed: %s", line);
                other_errs++;
                continue;
            end
            pat_lane0.push_back(exe_op_pkg::lane_req_t'({op0, a0, b0}));
            pat_lane1.push_back(exe_op_pkg::lane_req_t'({op1, a1, b1}));
            pat_flush.push_back(fl);
            exp_res0.push_back(exe_op_pkg::lane_res_t'({d0, o0, t0}));
            exp_res1.push_back(exe_op_pkg::lane_res_t'({d1, o1, t1}));
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////

    // Multiply and divide kinds hold the stage for several cycles.
    function automatic logic runs_multicycle(input exe_op_pkg::exe_op_e op);
        return op inside {[exe_op_pkg::OP_MULT:exe_op_pkg::OP_MSUBU]};
    endfunction

    task automatic idle_pairs(input int n);
        repeat (n) begin
            @(posedge clk);
            lane0 <= '0;
            lane1 <= '0;
            flush <= '0;
        end
    endtask

    task automatic check_lane(input string name, input exe_op_pkg::lane_res_t act,
                              input exe_op_pkg::lane_res_t exp);
        assert (act.data === exp.data) else begin
            $display("error: time %0t %s.data expected %h actual %h",
                     $time, name, exp.data, act.data);
            data_errs++;
        end
        assert (act.overflow === exp.overflow) else begin
            $display("error: time %0t %s.overflow expected %b actual %b",
                     $time, name, exp.overflow, act.overflow);
            flag_errs++;
        end
        assert (act.trap === exp.trap) else begin
            $display("error: time %0t %s.trap expected %b actual %b",
                     $time, name, exp.trap, act.trap);
            flag_errs++;
        end
    endtask

    task automatic run_pattern(input int idx);
        logic late;
        late = runs_multicycle(pat_lane0[idx].op) || runs_multicycle(pat_lane1[idx].op);
        @(posedge clk);
        lane0 <= pat_lane0[idx];
        lane1 <= pat_lane1[idx];
        flush <= late ? 2'b00 : pat_flush[idx];
        @(negedge clk);
        // Only a multiply or divide holds the stage in its first cycle.
        assert (stall === late) else begin
            $display("error: time %0t stall_o expected %b actual %b", $time, late, stall);
            stall_errs++;
        end
        // A flush for a running operation arrives one cycle after its start.
        if (late) begin
            @(posedge clk);
            flush <= pat_flush[idx];
            @(negedge clk);
        end
        while (stall) begin
            @(negedge clk);
        end
        check_lane("res0_o", res0, exp_res0[idx]);
        check_lane("res1_o", res1, exp_res1[idx]);
    endtask

    initial begin
        int total;
        void'($urandom(32'h2c2e4722));
        reset_i = 1'b1;
        lane0   = '0;
        lane1   = '0;
        flush   = '0;
        read_patterns();
        if (pat_lane0.size() == 0) begin
            $display("no patterns were read");
            other_errs++;
        end
        cycle_limit = pat_lane0.size() * (`EXE_DIV_CYCLES + 8)
                    + MAX_IDLE * pat_lane0.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        idle_pairs(2);
        for (int i = 0; i < pat_lane0.size(); i++) begin
            idle_pairs($urandom % (MAX_IDLE + 1));
            run_pattern(i);
        end
        idle_pairs(2);
        total = data_errs + flag_errs + stall_errs + other_errs + exe_top_i.chk_i.fail_cnt;
        $display("errors: data %0d, flags %0d, stall %0d, assertions %0d, other %0d",
                 data_errs, flag_errs, stall_errs, exe_top_i.chk_i.fail_cnt, other_errs);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
